//--- Bender.yml
package:
  name: merge_generator

sources:
  - files:
      - common/merge_pkg.sv
      - source/sync_fifo.sv
      - merge_generator/merge_control.sv
      - merge_generator/merge_datapath.sv
      - merge_generator/merge_generator_top.sv
  - target: test
    files:
      - verif/merge_generator_tb.sv

//--- common/merge_pkg.sv
// ------------------------------
// Lane merge shared definitions
// Sizes, FIFO levels, state and mode enums
// Merged word with scalar and byte views
// ------------------------------

`default_nettype none

package merge_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int LANE_COUNT = 4;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int COUNT_W    = 16;

    // FIFO defaults, prog_full at half depth
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic {
        MERGE_SUM  = 1'b0,
        MERGE_PACK = 1'b1
    } merge_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_CONFIG_REQ  = 3'd1,
        ST_CONFIG_WAIT = 3'd2,
        ST_BUSY        = 3'd3,
        ST_PAUSE       = 3'd4,
        ST_DONE        = 3'd5
    } merge_state_t;

    // Sum mode fills the word, pack mode fills one byte per lane
    // Lane 0 sits in the least significant byte
    typedef union packed {
        logic [DATA_W-1:0]                  word;
        logic [LANE_COUNT-1:0][BYTE_W-1:0]  lane_byte;
    } merge_word_t;

endpackage : merge_pkg

`default_nettype wire

//--- merge_generator/merge_control.sv
// ------------------------------
// Merge job FSM
// Remaining merge counter, drain delay
// Done level
// ------------------------------

`default_nettype none

module merge_control (
    input  logic                             ap_clk,
    input  logic                             areset_generator,
    input  logic                             start,
    input  logic                             config_valid,
    input  logic [merge_pkg::COUNT_W-1:0]    config_count,
    input  logic [merge_pkg::LANE_COUNT-1:0] lane_empty,
    input  logic                             out_prog_full,
    output logic                             config_request,
    output logic                             config_load,
    output logic                             merge_fire,
    output logic                             done
);
    import merge_pkg::*;

    merge_state_t       state;
    merge_state_t       state_next;
    logic [COUNT_W-1:0] remaining;
    logic               drain;
    logic               lanes_ready;
    logic               job_open;
    logic               zero_count;
    logic               last_fire;

    // ------------------------------
    // Decode
    // ------------------------------
    assign lanes_ready = ~|lane_empty;

    // A finished job accepts the next start once done is up
    assign job_open = start && ((state == ST_IDLE) || ((state == ST_DONE) && done));

    assign config_request = (state == ST_CONFIG_REQ);
    assign config_load    = (state == ST_CONFIG_WAIT) && config_valid;
    assign zero_count     = (config_count == '0);

    // Fire only with every lane holding a word and room downstream
    assign merge_fire = (state == ST_BUSY) && lanes_ready && !out_prog_full;
    assign last_fire  = merge_fire && (remaining == COUNT_W'(1));

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (job_open) begin
                    state_next = ST_CONFIG_REQ;
                end
            end
            ST_CONFIG_REQ: begin
                state_next = ST_CONFIG_WAIT;
            end
            ST_CONFIG_WAIT: begin
                if (config_load) begin
                    state_next = zero_count ? ST_DONE : ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (last_fire) begin
                    state_next = ST_DONE;
                end else if (out_prog_full) begin
                    state_next = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (!out_prog_full) begin
                    state_next = ST_BUSY;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------
    // Counter and done
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            remaining <= '0;
        end else if (config_load) begin
            remaining <= config_count;
        end else if (merge_fire) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Drain covers the datapath register, so done trails the
    // final word into the output FIFO
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            drain <= 1'b0;
            done  <= 1'b0;
        end else begin
            drain <= last_fire || (config_load && zero_count);
            if (job_open) begin
                done <= 1'b0;
            end else if (drain) begin
                done <= 1'b1;
            end
        end
    end

endmodule : merge_control

`default_nettype wire

//--- merge_generator/merge_datapath.sv
// ------------------------------
// Merge datapath
// Job mode register
// Registered sum or byte pack of lane heads
// ------------------------------

`default_nettype none

module merge_datapath (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   config_load,
    input  merge_pkg::merge_mode_t config_mode,
    input  logic                   merge_fire,
    input  merge_pkg::merge_word_t lane_head [merge_pkg::LANE_COUNT],
    output logic                   merged_valid,
    output merge_pkg::merge_word_t merged_word
);
    import merge_pkg::*;

    merge_mode_t       mode_q;
    logic [DATA_W-1:0] lane_sum;

    // ------------------------------
    // Mode
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mode_q <= MERGE_SUM;
        end else if (config_load) begin
            mode_q <= config_mode;
        end
    end

    // Wraps modulo 2^32
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            lane_sum = lane_sum + lane_head[i].word;
        end
    end

    // ------------------------------
    // Merge register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            merged_valid <= 1'b0;
        end else begin
            merged_valid <= merge_fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (merge_fire) begin
            if (mode_q == MERGE_SUM) begin
                merged_word.word <= lane_sum;
            end else begin
                // Low byte of each lane, lane 0 lowest
                for (int i = 0; i < LANE_COUNT; i++) begin
                    merged_word.lane_byte[i] <= lane_head[i].lane_byte[0];
                end
            end
        end
    end

endmodule : merge_datapath

`default_nettype wire

//--- merge_generator/merge_generator_top.sv
// ------------------------------
// Lane merge generator top
// Lane FIFOs, control, datapath, output FIFO
// ------------------------------

`default_nettype none

module merge_generator_top (
    input  logic                             ap_clk,
    input  logic                             areset_generator,
    input  logic                             start,
    output logic                             config_request,
    input  logic                             config_valid,
    input  merge_pkg::merge_mode_t           config_mode,
    input  logic [merge_pkg::COUNT_W-1:0]    config_count,
    input  logic [merge_pkg::LANE_COUNT-1:0] lane_valid,
    input  logic [merge_pkg::DATA_W-1:0]     lane_data [merge_pkg::LANE_COUNT],
    output logic [merge_pkg::LANE_COUNT-1:0] lane_full,
    output logic                             out_valid,
    output logic [merge_pkg::DATA_W-1:0]     out_data,
    input  logic                             out_rd_en,
    output logic                             done
);
    import merge_pkg::*;

    merge_word_t           lane_head [LANE_COUNT];
    logic [LANE_COUNT-1:0] lane_empty;
    logic                  config_load;
    logic                  merge_fire;
    logic                  merged_valid;
    merge_word_t           merged_word;
    merge_word_t           out_head;
    logic                  out_empty;
    logic                  out_prog_full;

    // ------------------------------
    // Input lanes, all popped together by a merge
    // ------------------------------
    for (genvar g = 0; g < LANE_COUNT; g++) begin : gen_lane_fifo
        sync_fifo #(
            .DEPTH      (FIFO_DEPTH),
            .PROG_LEVEL (PROG_THRESH)
        ) u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (lane_valid[g]),
            .push_data        (lane_data[g]),
            .pop              (merge_fire),
            .pop_data         (lane_head[g]),
            .empty            (lane_empty[g]),
            .full             (lane_full[g]),
            .prog_full        ()
        );
    end

    merge_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_valid     (config_valid),
        .config_count     (config_count),
        .lane_empty       (lane_empty),
        .out_prog_full    (out_prog_full),
        .config_request   (config_request),
        .config_load      (config_load),
        .merge_fire       (merge_fire),
        .done             (done)
    );

    merge_datapath u_datapath (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_load      (config_load),
        .config_mode      (config_mode),
        .merge_fire       (merge_fire),
        .lane_head        (lane_head),
        .merged_valid     (merged_valid),
        .merged_word      (merged_word)
    );

    // ------------------------------
    // Output side
    // ------------------------------
    sync_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_LEVEL (PROG_THRESH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (merged_valid),
        .push_data        (merged_word),
        .pop              (out_rd_en),
        .pop_data         (out_head),
        .empty            (out_empty),
        .full             (),
        .prog_full        (out_prog_full)
    );

    assign out_valid = !out_empty;
    assign out_data  = out_head.word;

endmodule : merge_generator_top

`default_nettype wire

//--- source/sync_fifo.sv
// ------------------------------
// Synchronous first-word-fall-through FIFO
// Empty, full and programmable full flags
// ------------------------------

`default_nettype none

module sync_fifo #(
    parameter int DEPTH      = merge_pkg::FIFO_DEPTH,
    parameter int PROG_LEVEL = merge_pkg::PROG_THRESH
) (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   push,
    input  merge_pkg::merge_word_t push_data,
    input  logic                   pop,
    output merge_pkg::merge_word_t pop_data,
    output logic                   empty,
    output logic                   full,
    output logic                   prog_full
);
    import merge_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    merge_word_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             push_ok;
    logic             pop_ok;

    // Wrap at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    assign empty     = (fill == '0);
    assign full      = (fill == CNT_W'(DEPTH));
    assign prog_full = (fill >= CNT_W'(PROG_LEVEL));

    // Head word always on the read port
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop keeps the level
            case ({push_ok, pop_ok})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule : sync_fifo

`default_nettype wire

//--- verif/merge_generator_tb.sv
// ------------------------------
// Lane merge generator testbench
// Clock, reset, file driven jobs
// Output checks, watchdog, summary
// ------------------------------

`default_nettype none

module merge_generator_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import merge_pkg::*;

    localparam int MEM_WORDS     = 256;
    localparam int BACKPRESS_JOB = 2;
    localparam int STALL_JOB     = 3;
    localparam int STALL_CYCLES  = 20;

    logic                  ap_clk = 1'b0;
    logic                  areset_generator;
    logic                  start;
    logic                  config_request;
    logic                  config_valid;
    merge_mode_t           config_mode;
    logic [COUNT_W-1:0]    config_count;
    logic [LANE_COUNT-1:0] lane_valid;
    logic [DATA_W-1:0]     lane_data [LANE_COUNT];
    logic [LANE_COUNT-1:0] lane_full;
    logic                  out_valid;
    logic [DATA_W-1:0]     out_data;
    logic                  out_rd_en;
    logic                  done;

    logic [31:0] stim [MEM_WORDS];
    int          pushed [LANE_COUNT];
    int          num_jobs;
    int          total_count;
    int          errors;
    int          checks;
    bit          loaded;

    always #10 ap_clk = ~ap_clk;

    merge_generator_top uut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_request   (config_request),
        .config_valid     (config_valid),
        .config_mode      (config_mode),
        .config_count     (config_count),
        .lane_valid       (lane_valid),
        .lane_data        (lane_data),
        .lane_full        (lane_full),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_rd_en        (out_rd_en),
        .done             (done)
    );

    function automatic bit lanes_sent(input int count);
        bit all_sent;
        all_sent = 1'b1;
        for (int k = 0; k < LANE_COUNT; k++) begin
            if (pushed[k] < count) begin
                all_sent = 1'b0;
            end
        end
        return all_sent;
    endfunction

    // ------------------------------
    // Job processes
    // ------------------------------
    task automatic answer_config(input merge_mode_t mode, input int count);
        int delay;
        delay = 1 + ($urandom % 4);
        @(negedge ap_clk);
        while (!config_request) begin
            @(negedge ap_clk);
        end
        repeat (delay) @(posedge ap_clk);
        config_valid <= 1'b1;
        config_mode  <= mode;
        config_count <= COUNT_W'(count);
        @(posedge ap_clk);
        config_valid <= 1'b0;
    endtask

    task automatic push_lane(input int lane, input int base, input int count, input int delay);
        int sent;
        sent = 0;
        repeat (delay) @(posedge ap_clk);
        while (sent < count) begin
            @(negedge ap_clk);
            // A push still in flight is not yet counted in lane_full
            if (!lane_valid[lane] && !lane_full[lane] && (($urandom % 4) != 0)) begin
                @(posedge ap_clk);
                lane_valid[lane] <= 1'b1;
                lane_data[lane]  <= stim[base + 2 + sent * LANE_COUNT + lane];
                sent++;
                pushed[lane] = sent;
            end else begin
                @(posedge ap_clk);
                lane_valid[lane] <= 1'b0;
            end
        end
        if (sent > 0) begin
            @(posedge ap_clk);
            lane_valid[lane] <= 1'b0;
        end
    endtask

    task automatic read_outputs(input int job, input int base, input int count, input bit hold);
        int                got;
        bit                short_seen;
        logic [DATA_W-1:0] expected;
        got        = 0;
        short_seen = 1'b0;
        // Output held off until the lanes back up
        if (hold) begin
            @(negedge ap_clk);
            while ((lane_full == '0) && !lanes_sent(count)) begin
                @(negedge ap_clk);
            end
            checks++;
            if (lane_full == '0) begin
                errors++;
                $display("Error at %0t: job %0d held the output but no lane became full",
                         $time, job);
            end
        end
        while (got < count) begin
            @(negedge ap_clk);
            // Once done is up the rest of the job waits in the output FIFO
            if (done && !out_valid && !short_seen) begin
                short_seen = 1'b1;
                errors++;
                $display("Error at %0t: job %0d raised done with only %0d of %0d words out",
                         $time, job, got, count);
            end
            if (out_rd_en && out_valid) begin
                expected = stim[base + 2 + count * LANE_COUNT + got];
                checks++;
                if (out_data !== expected) begin
                    errors++;
                    $display("FAILED %0t: job %0d word %0d read %h, expected %h",
                             $time, job, got, out_data, expected);
                end
                got++;
            end
            @(posedge ap_clk);
            out_rd_en <= (got < count) && (($urandom % 4) != 0);
        end
    endtask

    task automatic watch_job(input int job, input int count, input bit stall);
        int requests;
        requests = 0;
        @(negedge ap_clk);
        checks++;
        if (done) begin
            errors++;
            $display("Error at %0t: job %0d still shows done after start", $time, job);
        end
        while (!done) begin
            if (config_request) begin
                requests++;
            end
            if (stall && (pushed[0] == 0) && out_valid) begin
                errors++;
                $display("Error at %0t: job %0d gave a word before lane 0 had data",
                         $time, job);
            end
            @(negedge ap_clk);
        end
        checks++;
        if (!lanes_sent(count)) begin
            errors++;
            $display("Error at %0t: job %0d raised done before all lane words were sent",
                     $time, job);
        end
        checks++;
        if (requests != 1) begin
            errors++;
            $display("Error at %0t: job %0d saw %0d configuration requests instead of one",
                     $time, job, requests);
        end
    endtask

    task automatic run_job(input int job, input int base);
        merge_mode_t mode;
        int          count;
        int          stall_delay;
        mode        = merge_mode_t'(stim[base][0]);
        count       = int'(stim[base + 1]);
        stall_delay = (job == STALL_JOB) ? STALL_CYCLES : 0;
        for (int k = 0; k < LANE_COUNT; k++) begin
            pushed[k] = 0;
        end
        @(posedge ap_clk);
        start <= 1'b1;
        @(posedge ap_clk);
        start <= 1'b0;
        fork
            answer_config(mode, count);
            push_lane(0, base, count, stall_delay);
            push_lane(1, base, count, 0);
            push_lane(2, base, count, 0);
            push_lane(3, base, count, 0);
            read_outputs(job, base, count, job == BACKPRESS_JOB);
            watch_job(job, count, stall_delay > 0);
        join
        // Whole job already sat in the output FIFO at done
        @(negedge ap_clk);
        checks++;
        if (out_valid) begin
            errors++;
            $display("FAILED %0t: job %0d left an extra output word", $time, job);
        end
        checks++;
        if (!done) begin
            errors++;
            $display("FAILED %0t: job %0d dropped done before the next start", $time, job);
        end
    endtask

    // ------------------------------
    // Main flow
    // ------------------------------
    initial begin : main_flow
        int base;
        areset_generator = 1'b1;
        start            = 1'b0;
        config_valid     = 1'b0;
        config_mode      = MERGE_SUM;
        config_count     = '0;
        lane_valid       = '0;
        out_rd_en        = 1'b0;
        for (int k = 0; k < LANE_COUNT; k++) begin
            lane_data[k] = '0;
            pushed[k]    = 0;
        end
        errors      = 0;
        checks      = 0;
        total_count = 0;
        void'($urandom(32'h6b6b));
        $readmemh("verif/merge_input.txt", stim);
        num_jobs = (^stim[0] === 1'bx) ? 0 : int'(stim[0]);
        base = 1;
        for (int j = 0; j < num_jobs; j++) begin
            total_count += int'(stim[base + 1]);
            base += 2 + int'(stim[base + 1]) * (LANE_COUNT + 1);
        end
        loaded = 1'b1;
        if (num_jobs == 0) begin
            errors++;
            $display("Error: the stimulus file holds no jobs");
        end

        repeat (16) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(negedge ap_clk);
        checks++;
        if (config_request || done || out_valid || (lane_full != '0)) begin
            errors++;
            $display("FAILED %0t: outputs not idle after reset", $time);
        end

        base = 1;
        for (int j = 0; j < num_jobs; j++) begin
            run_job(j, base);
            base += 2 + int'(stim[base + 1]) * (LANE_COUNT + 1);
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of eight cycles per merge plus fixed overhead
    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (num_jobs + total_count * 8 + 50) * 20;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
    end

endmodule : merge_generator_tb

`default_nettype wire

//--- verif/merge_input.txt
// Job count, then per job: mode (0 sum, 1 pack), merge count,
// lane 0 to 3 words of each merge, expected merged words in order
00000005
// Job 0 sum, last merge wraps around
00000000 00000003
00000001 00000002 00000003 00000004
10000000 20000000 30000000 40000000
ffffffff 00000001 80000000 80000001
0000000a a0000000 00000001
// Job 1 pack
00000001 00000003
12345678 9abcdef0 0badcafe deadbeef
00000011 00000022 00000033 00000044
aaaaaa01 bbbbbb02 cccccc03 dddddd04
effef078 44332211 04030201
// Job 2 sum with the output held, two merges per line
00000000 0000001c
10000000 01000000 00100000 00010000 10000001 01000001 00100001 00010001
10000002 01000002 00100002 00010002 10000003 01000003 00100003 00010003
10000004 01000004 00100004 00010004 10000005 01000005 00100005 00010005
10000006 01000006 00100006 00010006 10000007 01000007 00100007 00010007
10000008 01000008 00100008 00010008 10000009 01000009 00100009 00010009
1000000a 0100000a 0010000a 0001000a 1000000b 0100000b 0010000b 0001000b
1000000c 0100000c 0010000c 0001000c 1000000d 0100000d 0010000d 0001000d
1000000e 0100000e 0010000e 0001000e 1000000f 0100000f 0010000f 0001000f
10000010 01000010 00100010 00010010 10000011 01000011 00100011 00010011
10000012 01000012 00100012 00010012 10000013 01000013 00100013 00010013
10000014 01000014 00100014 00010014 10000015 01000015 00100015 00010015
10000016 01000016 00100016 00010016 10000017 01000017 00100017 00010017
10000018 01000018 00100018 00010018 10000019 01000019 00100019 00010019
1000001a 0100001a 0010001a 0001001a 1000001b 0100001b 0010001b 0001001b
11110000 11110004 11110008 1111000c 11110010 11110014 11110018 1111001c
11110020 11110024 11110028 1111002c 11110030 11110034 11110038 1111003c
11110040 11110044 11110048 1111004c 11110050 11110054 11110058 1111005c
11110060 11110064 11110068 1111006c
// Job 3 pack, lane 0 arrives late
00000001 00000004
00000a01 00000b02 00000c03 00000d04
11111110 22222220 33333330 44444440
000000ff 00000000 000000ff 00000000
87654321 0fedcba9 13579bdf 2468ace0
04030201 40302010 00ff00ff e0dfa921
// Job 4 sum, no merges
00000000 00000000

//--- vlog.f
common/merge_pkg.sv
source/sync_fifo.sv
merge_generator/merge_control.sv
merge_generator/merge_datapath.sv
merge_generator/merge_generator_top.sv
verif/merge_generator_tb.sv
